// File: sources.f
+incdir+tb
source/cpuControlPkg.sv
source/opcodeDecoder.sv
source/controlSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
tb/controlUnitTb.sv

// File: Bender.yml
package:
  name: cpu_control_unit

sources:
  - source/cpuControlPkg.sv
  - source/opcodeDecoder.sv
  - source/controlSequencer.sv
  - source/controlWordGen.sv
  - source/controlUnit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/controlUnitTb.sv

// File: tb/controlModel.svh
`ifndef controlModelSvh
`define controlModelSvh

localparam int numTests = 23;
localparam int haltHold = 20;  // halt cycles checked before reset

// test table: name, opcode, conFlag (2 picks a random flag)
string testNames [numTests] = '{
    "add", "sub", "and", "or", "ror", "rol", "shr", "shra", "shl",
    "addi", "andi", "ori", "neg", "not", "ld", "ldi", "st",
    "br flag 0", "br flag 1", "jr", "jal", "illegal", "halt"
};
opcodeT testOps [numTests] = '{
    opAdd, opSub, opAnd, opOr, opRor, opRol, opShr, opShra, opShl,
    opAddi, opAndi, opOri, opNeg, opNot, opLd, opLdi, opSt,
    opBr, opBr, opJr, opJal, 5'd15, opHalt
};
logic [1:0] testCons [numTests] = '{
    2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2,
    2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2,
    2'd0, 2'd1, 2'd2, 2'd2, 2'd2, 2'd2
};

function automatic int execSteps(opcodeT op);
    case (op)
        opAdd, opSub, opAnd, opOr, opRor, opRol, opShr, opShra, opShl,
        opAddi, opAndi, opOri, opNeg, opNot: return 3;
        opLd, opLdi, opSt, opBr:             return 5;
        opJr:                                return 1;
        opJal:                               return 2;
        default:                             return 0;  // illegal, halt
    endcase
endfunction

// position of the next reset step, counted from this reset step
function automatic int instrCycles(opcodeT op);
    if (op == opHalt)
        return 3 + haltHold;  // halt seen at positions 4 up to here
    return 4 + execSteps(op);
endfunction

function automatic aluOpT aluFor(opcodeT op);
    case (op)
        opAdd, opAddi: return aluAdd;
        opSub:         return aluSub;
        opAnd, opAndi: return aluAnd;
        opOr, opOri:   return aluOr;
        opRor:         return aluRor;
        opRol:         return aluRol;
        opShr:         return aluShr;
        opShra:        return aluShra;
        opShl:         return aluShl;
        opNeg:         return aluNeg;
        opNot:         return aluNot;
        default:       return aluNone;
    endcase
endfunction

function automatic controlWordT expectedWord(opcodeT op, int pos, logic con);
    controlWordT w;
    int          s;
    w = '0;
    s = pos - 4;  // execute step
    if (pos == 0 || (op != opHalt && pos >= instrCycles(op))) begin
        w.load.pcIn  = 1'b1;  // reset step
        w.load.clear = 1'b1;
    end else if (pos == 1) begin
        w.bus.pcOut  = 1'b1;
        w.load.marIn = 1'b1;
        w.load.incPc = 1'b1;
        w.load.zIn   = 1'b1;
    end else if (pos == 2) begin
        w.mem.read   = 1'b1;
        w.load.mdrIn = 1'b1;
    end else if (pos == 3) begin
        w.bus.mdrOut = 1'b1;
        w.load.irIn  = 1'b1;
    end else if (op == opHalt) begin
        w.halt = 1'b1;
    end else if (op == opJr || (op == opJal && s == 1)) begin
        w.bus.gra    = 1'b1;  // jump target into pc
        w.bus.rOut   = 1'b1;
        w.load.pcIn  = 1'b1;
    end else if (op == opJal) begin
        w.bus.pcOut  = 1'b1;  // link
        w.bus.grb    = 1'b1;
        w.bus.rIn    = 1'b1;
    end else if (op == opBr) begin
        case (s)
            0: begin
                w.bus.gra    = 1'b1;
                w.bus.rOut   = 1'b1;
                w.load.conIn = 1'b1;
            end
            1: begin
                w.bus.pcOut = 1'b1;
                w.load.yIn  = 1'b1;
            end
            2: begin
                w.bus.cOut  = 1'b1;
                w.aluOp     = aluAdd;
                w.load.zIn  = 1'b1;
            end
            3: begin
                if (con)
                    w.bus.zLowOut = 1'b1;  // taken
                else
                    w.load.incPc = 1'b1;
            end
            default: w.load.pcIn = con;
        endcase
    end else if (execSteps(op) == 5) begin  // ld, ldi, st
        case (s)
            0: begin
                w.bus.grb  = 1'b1;
                w.bus.rOut = 1'b1;
                w.load.yIn = 1'b1;
            end
            1: begin
                w.bus.cOut = 1'b1;
                w.aluOp    = aluAdd;
                w.load.zIn = 1'b1;
            end
            2: begin
                w.bus.zLowOut = 1'b1;
                w.load.marIn  = 1'b1;
            end
            3: begin
                w.load.mdrIn = 1'b1;
                if (op == opSt) begin
                    w.bus.gra  = 1'b1;
                    w.bus.rOut = 1'b1;
                end else begin
                    w.mem.read = 1'b1;
                end
            end
            default: begin
                if (op == opSt) begin
                    w.mem.write = 1'b1;
                end else begin
                    w.bus.mdrOut = 1'b1;
                    w.bus.gra    = 1'b1;
                    w.bus.rIn    = 1'b1;
                end
            end
        endcase
    end else begin  // three-step alu sequences
        case (s)
            0: begin
                w.bus.grb  = 1'b1;
                w.bus.rOut = 1'b1;
                w.load.yIn = 1'b1;
            end
            1: begin
                w.aluOp    = aluFor(op);
                w.load.zIn = 1'b1;
                if (op == opAddi || op == opAndi || op == opOri) begin
                    w.bus.cOut = 1'b1;
                end else if (op != opNeg && op != opNot) begin
                    w.bus.grc  = 1'b1;
                    w.bus.rOut = 1'b1;
                end
            end
            default: begin
                w.bus.zLowOut = 1'b1;
                w.bus.gra     = 1'b1;
                w.bus.rIn     = 1'b1;
            end
        endcase
    end
    return w;
endfunction

`endif

// File: tb/controlUnitTb.sv
`default_nettype none

module controlUnitTb import cpuControlPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic        Clock;
    logic        Reset;
    logic        conFlag;
    wordT        instr;
    controlWordT control;

    `include "controlModel.svh"

    string       curName;              // test in progress
    opcodeT      curOp;
    logic        curCon;
    int          pos;                  // cycles since the reset step
    logic        checking = 1'b0;
    controlWordT expWord;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          passedTests = 0;
    int          failedTests = 0;
    int          cycles = 0;
    int          cycleLimit = 1000;
    logic [31:0] rngState = 32'd51249;  // seed

    controlUnit dut0 (
        .Clock   (Clock),
        .Reset   (Reset),
        .instr   (instr),
        .conFlag (conFlag),
        .control (control)
    );

    always #4 Clock = ~Clock;  // 8 ns period

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic applyReset();
        checking = 1'b0;
        Reset    = 1'b1;
        repeat (5) @(posedge Clock);
        #1 Reset = 1'b0;  // now in the reset step
    endtask

    // entered in the reset step when fromReset is set, else in fetch0
    task automatic runTest(input string name, input opcodeT op,
                           input logic [1:0] conMode, input logic fromReset);
        int len;
        len      = instrCycles(op);
        rngState = xorshift(rngState);
        instr    = {op, rngState[26:0]};  // random fields below the opcode
        rngState = xorshift(rngState);
        curCon   = (conMode == 2'd2) ? rngState[0] : conMode[0];
        conFlag  = (conMode == 2'd2) ? curCon : ~curCon;  // fixed flag arrives at step 3
        curOp    = op;
        curName  = name;
        testErrors = 0;
        pos      = fromReset ? 0 : 1;
        checking = 1'b1;
        while (pos < len) begin
            @(posedge Clock);
            #1 pos = pos + 1;
            if (pos == 7)
                conFlag = curCon;  // branch reads the flag in steps 3 and 4
        end
        @(posedge Clock);  // last position, the next reset step, checked
        #1;
        totalErrors = totalErrors + testErrors;
        if (testErrors == 0) begin
            passedTests = passedTests + 1;
            $display("Test %s ok", name);
        end else begin
            failedTests = failedTests + 1;
            $display("Test %s failed with %0d wrong words", name, testErrors);
        end
    endtask

    // compare mid-cycle, well clear of the input changes
    always @(negedge Clock) begin
        if (checking) begin
            expWord = expectedWord(curOp, pos, curCon);
            if (control !== expWord) begin
                $display("Fail %s position %0d expected %h actual %h",
                         curName, pos, expWord, control);
                testErrors = testErrors + 1;
            end
        end
    end

    always @(posedge Clock) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        Clock   = 1'b0;
        Reset   = 1'b1;
        conFlag = 1'b0;
        instr   = '0;
        cycleLimit = 50 + 2 * 5 + instrCycles(opAdd) + 2;  // resets and last test
        for (int i = 0; i < numTests; i++) begin
            cycleLimit = cycleLimit + instrCycles(testOps[i]) + 2;
        end
        applyReset();
        for (int i = 0; i < numTests; i++) begin
            runTest(testNames[i], testOps[i], testCons[i], i == 0);
        end
        applyReset();  // only way out of halt
        runTest("add after halt", opAdd, 2'd2, 1'b1);
        $display("%0d tests passed, %0d tests failed, %0d wrong words",
                 passedTests, failedTests, totalErrors);
        if (failedTests == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`default_nettype none

module controlUnit import cpuControlPkg::*; (
    input  wire         Clock,
    input  wire         Reset,
    input  wordT        instr,    // instruction register, stable per instruction
    input  wire         conFlag,  // branch condition
    output controlWordT control   // strobes for this cycle
);

    instrClassT decClass;     // decoder output, used at fetch2
    aluOpT      decAluOp;
    phaseT      phase;
    stepT       step;
    instrClassT activeClass;  // latched copies
    aluOpT      activeAluOp;

    opcodeDecoder decoder0 (
        .instr      (instr),
        .instrClass (decClass),
        .aluOp      (decAluOp)
    );

    controlSequencer sequencer0 (
        .Clock       (Clock),
        .Reset       (Reset),
        .instrClass  (decClass),
        .aluOp       (decAluOp),
        .phase       (phase),
        .step        (step),
        .activeClass (activeClass),
        .activeAluOp (activeAluOp)
    );

    controlWordGen wordGen0 (
        .phase       (phase),
        .step        (step),
        .activeClass (activeClass),
        .activeAluOp (activeAluOp),
        .conFlag     (conFlag),
        .control     (control)
    );

endmodule

`default_nettype wire

// File: source/controlWordGen.sv
`default_nettype none

module controlWordGen import cpuControlPkg::*; (
    input  phaseT       phase,
    input  stepT        step,
    input  instrClassT  activeClass,
    input  aluOpT       activeAluOp,
    input  wire         conFlag,      // condition flip-flop from datapath
    output controlWordT control
);

    always_comb begin
        control = '0;  // everything idle unless set below
        case (phase)
            phReset: begin
                control.load.pcIn  = 1'b1;  // pc loads zero
                control.load.clear = 1'b1;
            end
            phFetch0: begin
                control.bus.pcOut  = 1'b1;  // pc to mar
                control.load.marIn = 1'b1;
                control.load.incPc = 1'b1;
                control.load.zIn   = 1'b1;
            end
            phFetch1: begin
                control.mem.read   = 1'b1;  // instruction into mdr
                control.load.mdrIn = 1'b1;
            end
            phFetch2: begin
                control.bus.mdrOut = 1'b1;  // mdr into ir
                control.load.irIn  = 1'b1;
            end
            phExec: begin
                case (activeClass)
                    clsAlu3, clsAluImm, clsUnary: begin
                        case (step)
                            3'd0: begin
                                control.bus.grb   = 1'b1;  // rb into y
                                control.bus.rOut  = 1'b1;
                                control.load.yIn  = 1'b1;
                            end
                            3'd1: begin
                                control.aluOp    = activeAluOp;
                                control.load.zIn = 1'b1;
                                if (activeClass == clsAlu3) begin
                                    control.bus.grc  = 1'b1;  // rc as operand b
                                    control.bus.rOut = 1'b1;
                                end else if (activeClass == clsAluImm) begin
                                    control.bus.cOut = 1'b1;  // constant as operand b
                                end
                            end
                            3'd2: begin
                                control.bus.zLowOut = 1'b1;  // result into ra
                                control.bus.gra     = 1'b1;
                                control.bus.rIn     = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    clsLoad, clsStore: begin
                        case (step)
                            3'd0: begin
                                control.bus.grb  = 1'b1;  // base register into y
                                control.bus.rOut = 1'b1;
                                control.load.yIn = 1'b1;
                            end
                            3'd1: begin
                                control.bus.cOut = 1'b1;  // base plus offset
                                control.aluOp    = activeAluOp;
                                control.load.zIn = 1'b1;
                            end
                            3'd2: begin
                                control.bus.zLowOut = 1'b1;  // address to mar
                                control.load.marIn  = 1'b1;
                            end
                            3'd3: begin
                                if (activeClass == clsLoad) begin
                                    control.mem.read = 1'b1;
                                end else begin
                                    control.bus.gra  = 1'b1;  // store data into mdr
                                    control.bus.rOut = 1'b1;
                                end
                                control.load.mdrIn = 1'b1;
                            end
                            3'd4: begin
                                if (activeClass == clsLoad) begin
                                    control.bus.mdrOut = 1'b1;  // loaded word into ra
                                    control.bus.gra    = 1'b1;
                                    control.bus.rIn    = 1'b1;
                                end else begin
                                    control.mem.write = 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                    clsBranch: begin
                        case (step)
                            3'd0: begin
                                control.bus.gra    = 1'b1;  // ra sets the flag
                                control.bus.rOut   = 1'b1;
                                control.load.conIn = 1'b1;
                            end
                            3'd1: begin
                                control.bus.pcOut = 1'b1;
                                control.load.yIn  = 1'b1;
                            end
                            3'd2: begin
                                control.bus.cOut = 1'b1;  // target address
                                control.aluOp    = activeAluOp;
                                control.load.zIn = 1'b1;
                            end
                            3'd3: begin
                                if (conFlag)
                                    control.bus.zLowOut = 1'b1;  // taken
                                else
                                    control.load.incPc = 1'b1;   // fall through
                            end
                            3'd4: control.load.pcIn = conFlag;
                            default: ;
                        endcase
                    end
                    clsJr: begin
                        control.bus.gra   = 1'b1;  // ra straight into pc
                        control.bus.rOut  = 1'b1;
                        control.load.pcIn = 1'b1;
                    end
                    clsJal: begin
                        if (step == 3'd0) begin
                            control.bus.pcOut = 1'b1;  // link address into rb
                            control.bus.grb   = 1'b1;
                            control.bus.rIn   = 1'b1;
                        end else begin
                            control.bus.gra   = 1'b1;  // jump target
                            control.bus.rOut  = 1'b1;
                            control.load.pcIn = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            phHalt:  control.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/controlSequencer.sv
`default_nettype none

module controlSequencer import cpuControlPkg::*; (
    input  wire        Clock,
    input  wire        Reset,
    input  instrClassT instrClass,   // from decoder, valid in fetch2
    input  aluOpT      aluOp,
    output phaseT      phase,
    output stepT       step,         // execute step index
    output instrClassT activeClass,  // held for the whole execute phase
    output aluOpT      activeAluOp
);

    stepT lastStep;

    // final step of the running sequence
    always_comb begin
        case (activeClass)
            clsAlu3, clsAluImm, clsUnary: lastStep = lastStepAlu;
            clsLoad, clsStore, clsBranch: lastStep = lastStepMem;
            clsJr:                        lastStep = lastStepJr;
            clsJal:                       lastStep = lastStepJal;
            default:                      lastStep = '0;  // never in phExec
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase       <= phReset;
            step        <= '0;
            activeClass <= clsIllegal;
            activeAluOp <= aluNone;
        end else begin
            case (phase)
                phReset:  phase <= phFetch0;  // pc cleared this cycle
                phFetch0: phase <= phFetch1;
                phFetch1: phase <= phFetch2;
                phFetch2: begin
                    activeClass <= instrClass;  // latch decode at end of fetch
                    activeAluOp <= aluOp;
                    step        <= '0;
                    case (instrClass)
                        clsIllegal: phase <= phReset;  // skip execute
                        clsHalt:    phase <= phHalt;
                        default:    phase <= phExec;
                    endcase
                end
                phExec: begin
                    if (step == lastStep) begin
                        phase <= phReset;  // back for the next instruction
                        step  <= '0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                phHalt:  phase <= phHalt;  // only reset leaves
                default: phase <= phReset;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/opcodeDecoder.sv
`default_nettype none

module opcodeDecoder import cpuControlPkg::*; (
    input  wordT       instr,       // instruction register
    output instrClassT instrClass,  // execute sequence to run
    output aluOpT      aluOp        // operation for the alu step
);

    opcodeT opcode;

    assign opcode = instr[opcodeMsb:opcodeLsb];  // top five bits

    always_comb begin
        instrClass = clsIllegal;  // dropped and undefined codes
        aluOp      = aluNone;
        case (opcode)
            // three-register alu
            opAdd:  begin instrClass = clsAlu3; aluOp = aluAdd;  end
            opSub:  begin instrClass = clsAlu3; aluOp = aluSub;  end
            opAnd:  begin instrClass = clsAlu3; aluOp = aluAnd;  end
            opOr:   begin instrClass = clsAlu3; aluOp = aluOr;   end
            opRor:  begin instrClass = clsAlu3; aluOp = aluRor;  end
            opRol:  begin instrClass = clsAlu3; aluOp = aluRol;  end
            opShr:  begin instrClass = clsAlu3; aluOp = aluShr;  end
            opShra: begin instrClass = clsAlu3; aluOp = aluShra; end
            opShl:  begin instrClass = clsAlu3; aluOp = aluShl;  end
            // constant as second operand
            opAddi: begin instrClass = clsAluImm; aluOp = aluAdd; end
            opAndi: begin instrClass = clsAluImm; aluOp = aluAnd; end
            opOri:  begin instrClass = clsAluImm; aluOp = aluOr;  end
            // single operand
            opNeg:  begin instrClass = clsUnary; aluOp = aluNeg; end
            opNot:  begin instrClass = clsUnary; aluOp = aluNot; end
            // address arithmetic uses the adder
            opLd, opLdi: begin
                instrClass = clsLoad;   // ld and ldi share a sequence
                aluOp      = aluAdd;
            end
            opSt: begin
                instrClass = clsStore;
                aluOp      = aluAdd;
            end
            opBr: begin
                instrClass = clsBranch;
                aluOp      = aluAdd;    // pc plus offset
            end
            opJr:   instrClass = clsJr;
            opJal:  instrClass = clsJal;
            opHalt: instrClass = clsHalt;
            default: begin
                instrClass = clsIllegal;
                aluOp      = aluNone;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/cpuControlPkg.sv
`default_nettype none

package cpuControlPkg;

    typedef logic [31:0] wordT;     // processor word, instruction register
    typedef logic [4:0]  opcodeT;   // opcode field of the instruction
    typedef logic [2:0]  stepT;     // execute step, 0 is the first after fetch2

    localparam int opcodeMsb = 31;  // opcode field position in instr
    localparam int opcodeLsb = 27;

    // opcode encodings, kept instructions only
    localparam opcodeT opLd   = 5'd0;
    localparam opcodeT opLdi  = 5'd1;
    localparam opcodeT opSt   = 5'd2;
    localparam opcodeT opAdd  = 5'd3;
    localparam opcodeT opSub  = 5'd4;
    localparam opcodeT opAnd  = 5'd5;
    localparam opcodeT opOr   = 5'd6;
    localparam opcodeT opRor  = 5'd7;
    localparam opcodeT opRol  = 5'd8;
    localparam opcodeT opShr  = 5'd9;
    localparam opcodeT opShra = 5'd10;
    localparam opcodeT opShl  = 5'd11;
    localparam opcodeT opAddi = 5'd12;
    localparam opcodeT opAndi = 5'd13;
    localparam opcodeT opOri  = 5'd14;
    localparam opcodeT opNeg  = 5'd17;
    localparam opcodeT opNot  = 5'd18;
    localparam opcodeT opBr   = 5'd19;
    localparam opcodeT opJal  = 5'd20;
    localparam opcodeT opJr   = 5'd21;
    localparam opcodeT opHalt = 5'd26;  // new encoding, unused slot

    // index of the final execute step per sequence length
    localparam stepT lastStepAlu = 3'd2;  // alu3, immediate, unary
    localparam stepT lastStepMem = 3'd4;  // load, store, branch
    localparam stepT lastStepJr  = 3'd0;
    localparam stepT lastStepJal = 3'd1;

    typedef enum logic [3:0] {
        clsAlu3, clsAluImm, clsUnary, clsLoad, clsStore,
        clsBranch, clsJr, clsJal, clsHalt, clsIllegal
    } instrClassT;

    typedef enum logic [3:0] {
        aluNone, aluAdd, aluSub, aluAnd, aluOr, aluRor,
        aluRol, aluShr, aluShra, aluShl, aluNeg, aluNot
    } aluOpT;

    typedef enum logic [2:0] {
        phReset, phFetch0, phFetch1, phFetch2, phExec, phHalt
    } phaseT;

    typedef struct packed {
        logic gra;      // register select from ra field
        logic grb;
        logic grc;
        logic rIn;      // selected register loads from bus
        logic rOut;     // selected register drives bus
        logic cOut;     // sign-extended constant onto bus
        logic pcOut;
        logic mdrOut;
        logic zLowOut;
    } busCtrlT;

    typedef struct packed {
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic marIn;
        logic mdrIn;
        logic conIn;    // evaluate branch condition
        logic incPc;
        logic clear;
    } loadCtrlT;

    typedef struct packed {
        logic read;
        logic write;
    } memCtrlT;

    typedef struct packed {
        busCtrlT  bus;
        loadCtrlT load;
        memCtrlT  mem;
        aluOpT    aluOp;
        logic     halt;
    } controlWordT;     // 25 bits, one word per cycle

endpackage

`default_nettype wire
